/* sources.f */
src/ac97_pkg.sv
src/ac97_frame_if.sv
src/debounce.sv
src/volume_control.sv
src/ac97_command_seq.sv
src/ac97_frame_engine.sv
src/ac97_link_control.sv
src/audio_codec_top.sv
test/audio_codec_checker.sv
test/audio_codec_assert.sv
test/audio_codec_tb.sv

/* src/ac97_command_seq.sv */
module ac97_command_seq
  import ac97_pkg::*;
(
  input logic clock_27mhz,
  input logic reset,
  input logic ready,
  input logic [volume_width-1:0] volume,
  ac97_frame_if.client link
);

  logic [step_width-1:0] step;
  logic [volume_width-1:0] attenuation;
  logic [cmd_word_width-1:0] command;

  // codec wants attenuation, not gain
  assign attenuation = volume_max - volume;

  always_comb begin
    command = cmd_table[step];
    if (step == hp_step) begin
      command[cmd_data_width-1:0] = {3'b000, attenuation, 3'b000, attenuation};
    end
  end

  // one register write per sample period, wrapping through the table
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      step <= '0;
      link.cmd_valid <= 1'b0;
    end else begin
      if (ready) begin
        step <= step + 1'b1;
      end
      if (step == '0) begin
        link.cmd_valid <= 1'b1;
      end
    end
  end

  // the engine picks this up at the end of a frame
  always_ff @(posedge clock_27mhz) begin
    link.cmd_address <= command[cmd_word_width-1:cmd_data_width];
    link.cmd_data <= command[cmd_data_width-1:0];
  end

endmodule

/* src/ac97_frame_engine.sv */
module ac97_frame_engine
  import ac97_pkg::*;
(
  input logic ac97_bit_clock,
  input logic reset,
  ac97_frame_if.engine link,
  output logic ac97_sdata_out,
  input logic ac97_sdata_in,
  output logic ac97_synch
);

  localparam int count_width = $clog2(frame_bits);
  // tag slot plus slots 1 to 4 go out through one shifter
  localparam int shift_bits = slot4_start + slot_width;

  localparam logic [count_width-1:0] last_bit = count_width'(frame_bits - 1);
  localparam logic [count_width-1:0] sync_on = count_width'(sync_start);
  localparam logic [count_width-1:0] sync_off = count_width'(sync_end);
  localparam logic [count_width-1:0] ready_on = count_width'(ready_start);
  localparam logic [count_width-1:0] ready_off = count_width'(ready_end);
  localparam logic [count_width-1:0] shift_end = count_width'(shift_bits);
  localparam logic [count_width-1:0] in_first = count_width'(slot3_start + 1);
  localparam logic [count_width-1:0] in_last = count_width'(slot3_start + slot_width);

  logic [1:0] reset_pipe;
  logic bit_reset;
  logic [count_width-1:0] bit_count;
  logic [shift_bits-1:0] out_shift;

  logic [slot1_start-1:0] tag_slot;
  logic [slot_width-1:0] addr_slot;
  logic [slot_width-1:0] data_slot;
  logic [slot_width-1:0] sample_slot;

  ////////////////////////////////////////////////////////////////////////////
  // reset into the bit-clock domain
  always_ff @(posedge ac97_bit_clock) begin
    reset_pipe <= {reset_pipe[0], reset};
  end

  assign bit_reset = reset_pipe[1];

  ////////////////////////////////////////////////////////////////////////////
  // outgoing frame contents, sampled at the last bit of a frame
  // frame valid, command address and data valid, left and right valid
  assign tag_slot = {1'b1, link.cmd_valid, link.cmd_valid, 2'b11, 11'b0};

  // command fields are left justified in their slots
  assign addr_slot = link.cmd_valid ?
      {link.cmd_address, {(slot_width - cmd_addr_width){1'b0}}} : '0;
  assign data_slot = link.cmd_valid ?
      {link.cmd_data, {(slot_width - cmd_data_width){1'b0}}} : '0;
  assign sample_slot = {link.pcm_out, {(slot_width - sample_width){1'b0}}};

  always_ff @(posedge ac97_bit_clock) begin
    if (bit_reset) begin
      bit_count <= '0;
      ac97_synch <= 1'b0;
      link.frame_ready <= 1'b0;
      ac97_sdata_out <= 1'b0;
      // first frame after reset only says frame valid
      out_shift <= {1'b1, {(shift_bits - 1){1'b0}}};
    end else begin
      bit_count <= bit_count + 1'b1;

      if (bit_count == sync_on) begin
        ac97_synch <= 1'b1;
      end else if (bit_count == sync_off) begin
        ac97_synch <= 1'b0;
      end

      if (bit_count == ready_on) begin
        link.frame_ready <= 1'b1;
      end else if (bit_count == ready_off) begin
        link.frame_ready <= 1'b0;
      end

      if (bit_count == last_bit) begin
        out_shift <= {tag_slot, addr_slot, data_slot, sample_slot, sample_slot};
      end else if (bit_count < shift_end) begin
        out_shift <= {out_shift[shift_bits-2:0], 1'b0};
      end

      // slots past the right channel stay quiet
      ac97_sdata_out <= (bit_count < shift_end) ? out_shift[shift_bits-1] : 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // incoming left slot, sampled on the falling edge
  always_ff @(negedge ac97_bit_clock) begin
    if (bit_count >= in_first && bit_count <= in_last) begin
      link.pcm_in <= {link.pcm_in[slot_width-2:0], ac97_sdata_in};
    end
  end

endmodule

/* src/ac97_frame_if.sv */
interface ac97_frame_if
  import ac97_pkg::*;
  ();

  // command word, quasi-static between ready pulses
  logic [cmd_addr_width-1:0] cmd_address;
  logic [cmd_data_width-1:0] cmd_data;
  logic cmd_valid;

  // samples in both directions
  logic [sample_width-1:0] pcm_out;
  logic [slot_width-1:0] pcm_in;

  // bit-clock domain, high for the second half of each frame
  logic frame_ready;

  modport engine (
    input cmd_address, cmd_data, cmd_valid, pcm_out,
    output pcm_in, frame_ready
  );

  modport client (
    output cmd_address, cmd_data, cmd_valid, pcm_out,
    input pcm_in, frame_ready
  );

endinterface

/* src/ac97_link_control.sv */
module ac97_link_control
  import ac97_pkg::*;
#(
  parameter int codec_reset_cycles = 1023
) (
  input logic clock_27mhz,
  input logic reset,
  input logic [sample_width-1:0] audio_out_data,
  output logic [sample_width-1:0] audio_in_data,
  output logic ready,
  output logic audio_reset_b,
  ac97_frame_if.client link
);

  localparam int count_width = $clog2(codec_reset_cycles + 1);

  logic [2:0] ready_sync;
  logic [count_width-1:0] reset_count;

  // frame_ready comes from the bit clock, first two flops settle it
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      ready_sync <= '0;
    end else begin
      ready_sync <= {ready_sync[1:0], link.frame_ready};
    end
  end

  assign ready = ready_sync[1] & ~ready_sync[2];

  // sample held for the engine until the next ready
  always_ff @(posedge clock_27mhz) begin
    if (ready) begin
      link.pcm_out <= audio_out_data;
    end
  end

  // low slot bits are below the 18-bit sample
  assign audio_in_data = link.pcm_in[slot_width-1:slot_width-sample_width];

  // codec stays in reset for a while after our own reset
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      audio_reset_b <= 1'b0;
      reset_count <= '0;
    end else if (!audio_reset_b) begin
      if (reset_count == count_width'(codec_reset_cycles - 1)) begin
        audio_reset_b <= 1'b1;
      end else begin
        reset_count <= reset_count + 1'b1;
      end
    end
  end

endmodule

/* src/ac97_pkg.sv */
package ac97_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // frame geometry, counted in bit clocks
  localparam int frame_bits = 256;
  localparam int slot_width = 20;
  localparam int sample_width = 18;
  localparam int cmd_addr_width = 8;
  localparam int cmd_data_width = 16;
  localparam int cmd_word_width = cmd_addr_width + cmd_data_width;

  // first bit of each slot, slot 0 (tags) starts at 0
  localparam int slot1_start = 16;
  localparam int slot2_start = 36;
  localparam int slot3_start = 56;
  localparam int slot4_start = 76;

  // sync and frame-ready windows
  localparam int sync_start = 255;
  localparam int sync_end = 15;
  localparam int ready_start = 128;
  localparam int ready_end = 2;

  ////////////////////////////////////////////////////////////////////////////
  // volume and codec setup
  localparam int volume_width = 5;
  localparam logic [volume_width-1:0] volume_reset = volume_width'(13);
  localparam logic [volume_width-1:0] volume_max = '1;

  localparam logic [2:0] mic_source = 3'd0;

  localparam int step_width = 4;
  localparam logic [step_width-1:0] hp_step = 4'd3;

  // headphone entry has empty volume fields, filled in by the sequencer
  localparam logic [cmd_word_width-1:0] cmd_table [2**step_width] = '{
    24'h80_0000, 24'h80_0000, 24'h80_0000, 24'h04_0000,
    24'h80_0000, 24'h18_0808, {8'h1A, 5'b00000, mic_source, 5'b00000, mic_source},
    24'h1C_0F0F, 24'h80_0000, 24'h0E_8048, 24'h0A_0000,
    24'h20_8000, 24'h80_0000, 24'h80_0000, 24'h80_0000, 24'h80_0000
  };

endpackage

/* src/audio_codec_top.sv */
module audio_codec_top #(
  parameter int debounce_cycles = 270000,
  parameter int codec_reset_cycles = 1023
) (
  input logic clock_27mhz,
  input logic reset,
  input logic button_up,
  input logic button_down,
  input logic [17:0] audio_out_data,
  output logic [17:0] audio_in_data,
  output logic ready,
  output logic [4:0] volume,
  output logic audio_reset_b,
  output logic ac97_sdata_out,
  input logic ac97_sdata_in,
  output logic ac97_synch,
  input logic ac97_bit_clock
);

  ////////////////////////////////////////////////////////////////////////////
  // link between the 27 MHz side and the bit-clock side
  ac97_frame_if link ();

  volume_control #(
    .debounce_cycles(debounce_cycles)
  ) volume_ctrl (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .volume(volume)
  );

  // register writes, one per ready
  ac97_command_seq command_seq (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .ready(ready),
    .volume(volume),
    .link(link.client)
  );

  ac97_frame_engine frame_engine (
    .ac97_bit_clock(ac97_bit_clock),
    .reset(reset),
    .link(link.engine),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in),
    .ac97_synch(ac97_synch)
  );

  ac97_link_control #(
    .codec_reset_cycles(codec_reset_cycles)
  ) link_ctrl (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .audio_out_data(audio_out_data),
    .audio_in_data(audio_in_data),
    .ready(ready),
    .audio_reset_b(audio_reset_b),
    .link(link.client)
  );

endmodule

/* src/debounce.sv */
module debounce #(
  parameter int debounce_cycles = 270000
) (
  input logic clock_27mhz,
  input logic reset,
  input logic noisy,
  output logic clean
);

  localparam int count_width = $clog2(debounce_cycles + 1);

  logic [count_width-1:0] count;
  logic sample;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      count <= '0;
      sample <= noisy;
      clean <= noisy;
    end else if (noisy != sample) begin
      // input moved, start the stability window again
      sample <= noisy;
      count <= '0;
    end else if (count == count_width'(debounce_cycles)) begin
      clean <= sample;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

/* src/volume_control.sv */
module volume_control
  import ac97_pkg::*;
#(
  parameter int debounce_cycles = 270000
) (
  input logic clock_27mhz,
  input logic reset,
  input logic button_up,
  input logic button_down,
  output logic [volume_width-1:0] volume
);

  logic up_clean;
  logic down_clean;
  logic up_prev;
  logic down_prev;

  // buttons are active low on the board
  debounce #(
    .debounce_cycles(debounce_cycles)
  ) up_filter (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .noisy(~button_up),
    .clean(up_clean)
  );

  debounce #(
    .debounce_cycles(debounce_cycles)
  ) down_filter (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .noisy(~button_down),
    .clean(down_clean)
  );

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      volume <= volume_reset;
      up_prev <= 1'b0;
      down_prev <= 1'b0;
    end else begin
      up_prev <= up_clean;
      down_prev <= down_clean;
      // one step per press, held at the ends of the range
      if (up_clean && !up_prev && volume != volume_max) begin
        volume <= volume + 1'b1;
      end else if (down_clean && !down_prev && volume != '0) begin
        volume <= volume - 1'b1;
      end
    end
  end

endmodule

/* test/audio_codec_assert.sv */
module ac97_frame_assert (
  input logic ac97_bit_clock,
  input logic bit_reset,
  input logic [7:0] bit_count,
  input logic frame_ready,
  input logic ac97_synch,
  input logic ac97_sdata_out
);

  // sync covers bits 255 through 15 of the frame
  sync_rise: assert property (@(posedge ac97_bit_clock) disable iff (bit_reset)
    $rose(ac97_synch) |-> bit_count == 8'd0)
    else $error("sync rose away from the frame start");

  sync_fall: assert property (@(posedge ac97_bit_clock) disable iff (bit_reset)
    $fell(ac97_synch) |-> bit_count == 8'd16)
    else $error("sync fell away from bit 15");

  // one rise per frame, at bit 128
  ready_rise: assert property (@(posedge ac97_bit_clock) disable iff (bit_reset)
    $rose(frame_ready) |-> bit_count == 8'd129)
    else $error("frame_ready rose away from bit 128");

  // nothing driven past the right channel slot
  quiet_slots: assert property (@(posedge ac97_bit_clock) disable iff (bit_reset)
    (bit_count == 8'd0 || bit_count > 8'd96) |-> !ac97_sdata_out)
    else $error("sdata_out high outside slots 0 through 4");

endmodule

bind ac97_frame_engine ac97_frame_assert frame_checks (
  .ac97_bit_clock(ac97_bit_clock),
  .bit_reset(bit_reset),
  .bit_count(bit_count),
  .frame_ready(link.frame_ready),
  .ac97_synch(ac97_synch),
  .ac97_sdata_out(ac97_sdata_out)
);

/* test/audio_codec_checker.sv */
module audio_codec_checker
  import ac97_pkg::*;
(
  input logic clock_27mhz,
  input logic reset,
  input logic ready,
  input logic [4:0] volume,
  input logic audio_reset_b,
  input logic [17:0] audio_in_data,
  input logic ac97_bit_clock,
  input logic ac97_synch,
  input logic ac97_sdata_out
);

  localparam int frame_top = slot4_start + slot_width - 1;

  int errors = 0;
  int tests = 0;
  int passed = 0;
  int cmd_errors = 0;
  int ready_errors = 0;

  logic [frame_top:0] frame_shift;
  logic [frame_top:0] last_frame = '0;
  int frame_pos = 0;
  logic bit_synch_prev = 1'b0;
  logic [4:0] frame_vol = '0;
  int stable_frames = 0;
  int hp_checked = 0;

  logic ready_prev;
  logic synch_prev;
  int ready_count;
  int sync_count;
  int release_count;
  bit release_seen;
  bit release_ok;

  task automatic finish_test(input string name, input bit ok);
    tests++;
    if (ok) begin
      passed++;
      $display("test %0d %s: passed", tests, name);
    end else begin
      errors++;
      $display("test %0d %s: failed", tests, name);
    end
  endtask

  task automatic fail_test(input string what);
    $display("%s", what);
    finish_test("stimulus", 1'b0);
  endtask

  task automatic check_volume(input string name, input logic [4:0] expected);
    if (volume !== expected) begin
      $display("MISMATCH volume expected %h got %h", expected, volume);
    end
    finish_test(name, volume === expected);
  endtask

  task automatic check_send(input logic [19:0] expected);
    logic [19:0] left;
    logic [19:0] right;
    bit ok;
    left = last_frame[frame_top-slot3_start -: slot_width];
    right = last_frame[frame_top-slot4_start -: slot_width];
    ok = (left === expected) && (right === expected);
    if (left !== expected) begin
      $display("MISMATCH slot3 expected %h got %h", expected, left);
    end
    if (right !== expected) begin
      $display("MISMATCH slot4 expected %h got %h", expected, right);
    end
    if (last_frame[frame_top-3 -: 2] !== 2'b11) begin
      $display("left and right tags are not both set");
      ok = 1'b0;
    end
    finish_test("send_pcm", ok);
  endtask

  task automatic check_recv(input logic [17:0] expected);
    if (audio_in_data !== expected) begin
      $display("MISMATCH audio_in_data expected %h got %h", expected, audio_in_data);
    end
    finish_test("recv_pcm", audio_in_data === expected);
  endtask

  task automatic check_commands();
    if (hp_checked == 0) begin
      $display("no headphone command seen while the volume was settled");
    end
    finish_test("command words", hp_checked > 0 && cmd_errors == 0);
  endtask

  task automatic check_codec_reset();
    if (!release_seen) begin
      $display("codec reset was never released");
    end
    finish_test("codec reset release", release_seen && release_ok);
  endtask

  task automatic check_ready_pulses();
    if (sync_count < 3) begin
      $display("too few frames seen to check the ready pulses");
    end
    finish_test("ready pulses", ready_errors == 0 && sync_count >= 3);
  endtask

  task automatic report();
    $display("tests %0d passed %0d errors %0d", tests, passed, errors);
  endtask

  // every valid command must come from the register table
  task automatic check_frame(input logic [frame_top:0] frame);
    logic [19:0] addr_slot;
    logic [19:0] data_slot;
    logic [7:0] addr;
    logic [15:0] data;
    logic [4:0] att;
    addr_slot = frame[frame_top-slot1_start -: slot_width];
    data_slot = frame[frame_top-slot2_start -: slot_width];
    addr = addr_slot[19:12];
    data = data_slot[19:4];
    att = 5'd31 - volume;
    if (volume == frame_vol) begin
      stable_frames++;
    end else begin
      stable_frames = 0;
      frame_vol = volume;
    end
    if (frame[frame_top-1] && frame[frame_top-2]) begin
      if (addr_slot[11:0] != 0 || data_slot[3:0] != 0) begin
        $display("command slots are not left justified");
        cmd_errors++;
      end
      case (addr)
        8'h80: begin
          if (data !== 16'h0000) begin
            $display("MISMATCH cmd_data expected %h got %h", 16'h0000, data);
            cmd_errors++;
          end
        end
        8'h1A: begin
          if (data !== {5'b0, mic_source, 5'b0, mic_source}) begin
            $display("MISMATCH cmd_data expected %h got %h",
                     {5'b0, mic_source, 5'b0, mic_source}, data);
            cmd_errors++;
          end
        end
        8'h04: begin
          if (stable_frames >= 2) begin
            hp_checked++;
            if (data !== {3'b000, att, 3'b000, att}) begin
              $display("MISMATCH cmd_data expected %h got %h",
                       {3'b000, att, 3'b000, att}, data);
              cmd_errors++;
            end
          end
        end
        8'h18, 8'h1C, 8'h0E, 8'h0A, 8'h20: begin
        end
        default: begin
          $display("command address %h is not in the register table", addr);
          cmd_errors++;
        end
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // frame decoder, outputs settle on the rising bit clock
  // first frame bit follows the sync rise by one bit clock
  always @(negedge ac97_bit_clock) begin
    if (ac97_synch && !bit_synch_prev) begin
      frame_shift = '0;
      frame_pos = 1;
    end else if (frame_pos > 0 && frame_pos <= frame_top + 1) begin
      frame_shift = {frame_shift[frame_top-1:0], ac97_sdata_out};
      frame_pos++;
      if (frame_pos == frame_top + 2) begin
        last_frame = frame_shift;
        check_frame(frame_shift);
      end
    end
    bit_synch_prev = ac97_synch;
  end

  ////////////////////////////////////////////////////////////////////////////
  // ready pulses and codec reset, sampled mid cycle
  always @(negedge clock_27mhz) begin
    if (reset) begin
      ready_prev = 1'b0;
      synch_prev = 1'b0;
      ready_count = 0;
      sync_count = 0;
      release_count = 0;
      release_seen = 1'b0;
      release_ok = 1'b1;
    end else begin
      if (ready && ready_prev) begin
        $display("ready stayed high for more than one cycle");
        ready_errors++;
      end
      if (ready) begin
        ready_count++;
      end
      if (ac97_synch && !synch_prev) begin
        if (sync_count >= 2 && ready_count != 1) begin
          $display("expected one ready pulse per frame but saw %0d", ready_count);
          ready_errors++;
        end
        ready_count = 0;
        sync_count++;
      end
      ready_prev = ready;
      synch_prev = ac97_synch;
      if (!release_seen) begin
        release_count++;
        if (audio_reset_b) begin
          release_seen = 1'b1;
          if (release_count != 40) begin
            $display("codec reset released after %0d cycles instead of 40", release_count);
            release_ok = 1'b0;
          end
        end
      end else if (!audio_reset_b) begin
        $display("codec reset asserted again after release");
        release_ok = 1'b0;
      end
    end
  end

endmodule

/* test/audio_codec_stimulus.txt */
# columns: operation, argument in hex, expected value in hex
# press_* argument is a press count, send_pcm expects slot bits, recv_pcm expects the sample
press_up 1 0e
press_down 1 0d
press_up 14 1f
send_pcm 2abcd aaf34
press_down 28 00
recv_pcm 5a5a5 16969
send_pcm 3ffff ffffc
recv_pcm 0000f 00003
press_up 3 03
send_pcm 00001 00004

/* test/audio_codec_tb.sv */
module audio_codec_tb;

  localparam int frame_cycles = 640;
  localparam int press_hold = 20;

  logic clock_27mhz = 1'b0;
  logic ac97_bit_clock = 1'b0;
  logic reset;
  logic button_up;
  logic button_down;
  logic [17:0] audio_out_data;
  logic [17:0] audio_in_data;
  logic ready;
  logic [4:0] volume;
  logic audio_reset_b;
  logic ac97_sdata_out;
  logic ac97_sdata_in;
  logic ac97_synch;

  // codec side model state
  logic [19:0] rx_word;
  logic codec_synch_prev;
  int codec_pos;
  int next_pos;
  integer seed;

  string op_q[$];
  logic [19:0] arg_q[$];
  logic [19:0] exp_q[$];
  int cycles;
  int cycle_limit;

  audio_codec_top #(
    .debounce_cycles(8),
    .codec_reset_cycles(40)
  ) uut (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .audio_out_data(audio_out_data),
    .audio_in_data(audio_in_data),
    .ready(ready),
    .volume(volume),
    .audio_reset_b(audio_reset_b),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in),
    .ac97_synch(ac97_synch),
    .ac97_bit_clock(ac97_bit_clock)
  );

  audio_codec_checker check_unit (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .ready(ready),
    .volume(volume),
    .audio_reset_b(audio_reset_b),
    .audio_in_data(audio_in_data),
    .ac97_bit_clock(ac97_bit_clock),
    .ac97_synch(ac97_synch),
    .ac97_sdata_out(ac97_sdata_out)
  );

  always #4 clock_27mhz = ~clock_27mhz;
  always #10 ac97_bit_clock = ~ac97_bit_clock;

  ////////////////////////////////////////////////////////////////////////////
  // codec model, position tracked from sync on the falling edge
  always @(negedge ac97_bit_clock) begin
    if (ac97_synch && !codec_synch_prev) begin
      codec_pos = 0;
    end else begin
      codec_pos = (codec_pos + 1) % 256;
    end
    codec_synch_prev = ac97_synch;
  end

  // left slot bits go out msb first, everything else is filler
  always @(posedge ac97_bit_clock) begin
    next_pos = (codec_pos + 1) % 256;
    if (next_pos >= 57 && next_pos <= 76) begin
      ac97_sdata_in <= rx_word[76-next_pos];
    end else begin
      ac97_sdata_in <= $random(seed) & 1;
    end
  end

  always @(posedge clock_27mhz) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic wait_ready(input int count);
    int seen;
    seen = 0;
    while (seen < count) begin
      @(negedge clock_27mhz);
      if (ready) begin
        seen++;
      end
    end
  endtask

  task automatic press_button(input bit up);
    @(negedge clock_27mhz);
    if (up) begin
      button_up <= 1'b0;
    end else begin
      button_down <= 1'b0;
    end
    repeat (press_hold) @(negedge clock_27mhz);
    button_up <= 1'b1;
    button_down <= 1'b1;
    repeat (press_hold) @(negedge clock_27mhz);
  endtask

  task automatic read_stimulus();
    int fd;
    int status;
    string line;
    string op;
    logic [19:0] arg;
    logic [19:0] expected;
    fd = $fopen("test/audio_codec_stimulus.txt", "r");
    if (fd == 0) begin
      check_unit.fail_test("could not open the stimulus file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        status = $fgets(line, fd);
        if (line.len() > 0 && line[0] != "#") begin
          status = $sscanf(line, "%s %h %h", op, arg, expected);
          if (status == 3) begin
            op_q.push_back(op);
            arg_q.push_back(arg);
            exp_q.push_back(expected);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    reset = 1'b1;
    button_up = 1'b1;
    button_down = 1'b1;
    audio_out_data = '0;
    ac97_sdata_in = 1'b0;
    rx_word = '0;
    codec_synch_prev = 1'b0;
    codec_pos = 200;
    seed = 32'hd640;
    cycles = 0;
    cycle_limit = 1000000;
    read_stimulus();
    // six frames per operation plus reset and codec delay
    cycle_limit = op_q.size() * 6 * frame_cycles + 8 + 40;

    repeat (8) @(negedge clock_27mhz);
    reset <= 1'b0;
    @(negedge clock_27mhz);
    check_unit.check_volume("reset volume", 5'd13);

    foreach (op_q[i]) begin
      case (op_q[i])
        "press_up", "press_down": begin
          repeat (arg_q[i]) press_button(op_q[i] == "press_up");
          check_unit.check_volume(op_q[i], exp_q[i][4:0]);
        end
        "send_pcm": begin
          @(negedge clock_27mhz);
          audio_out_data <= arg_q[i][17:0];
          wait_ready(3);
          check_unit.check_send(exp_q[i]);
        end
        "recv_pcm": begin
          @(negedge clock_27mhz);
          rx_word <= arg_q[i];
          wait_ready(3);
          check_unit.check_recv(exp_q[i][17:0]);
        end
        default: begin
          check_unit.fail_test({"unknown operation ", op_q[i]});
        end
      endcase
    end

    // let the command table wrap with a settled volume
    wait_ready(18);
    check_unit.check_commands();
    check_unit.check_codec_reset();
    check_unit.check_ready_pulses();
    check_unit.report();
    if (check_unit.errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
